//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary -j 0 --top-module tb_wordle -f tb.f
	./obj_dir/Vtb_wordle | tee /dev/stderr | grep "All checks passed" > /dev/null

lint:
	verilator --lint-only -Wall --timing --top-module tb_wordle -f tb.f

clean:
	rm -rf obj_dir

//--- common/wordle_consts.svh
`ifndef WORDLE_CONSTS_SVH
`define WORDLE_CONSTS_SVH

// Word and letter geometry
`define WORD_LEN 4
`define LETTER_W 5

// Board I/O, segments are active low
`define SEG_W 7
`define SW_W 10

// Game rules
`define MAX_GUESSES 5

// Lexicon size per level
`define LEX_DEPTH 8
`define SEL_W 3

// Marks a switch pattern that is no letter
`define LETTER_NONE 5'd31

`endif

//--- common/wordle_pkg.sv
`include "wordle_consts.svh"

package wordle_pkg;

	typedef logic [`LETTER_W-1:0] letter_t; // A is 0, Z is 25
	typedef letter_t [0:`WORD_LEN-1] word_t; // Element 0 is leftmost
	typedef logic [`SEG_W-1:0] seg_t;
	typedef seg_t [0:`WORD_LEN-1] seg_word_t;
	typedef logic [`WORD_LEN-1:0] mask_t; // Bit i follows word element i

	typedef enum logic [1:0] {
		LVL_NONE,
		LVL_EASY,
		LVL_MEDIUM,
		LVL_HARD
	} level_t;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_GUESSING,
		PH_WON,
		PH_LOST,
		PH_REVEAL
	} phase_t;

	typedef struct packed {
		letter_t letter;
		level_t level;
	} entry_t;

	typedef struct packed {
		mask_t mask;
		logic hit; // Every position matched
	} score_t;

	typedef struct packed {
		logic win;
		logic lose;
	} status_t;

	// Bits 9..3 one-hot inside a group, bits 2..0 pick the group
	function automatic letter_t decode_letter(input logic [`SW_W-1:0] sw);
		logic [2:0] hot_cnt;
		logic [2:0] hot_pos;
		logic [4:0] base;
		logic group_ok;
		letter_t result;
		hot_cnt = '0;
		hot_pos = '0;
		for (int i = 0; i < 7; i++) begin
			if (sw[`SW_W-1-i]) begin
				hot_cnt = hot_cnt + 3'd1;
				hot_pos = 3'(i);
			end
		end
		group_ok = 1'b1;
		case (sw[2:0])
			3'b000: base = 5'd0; // A-G
			3'b001: base = 5'd7; // H-N
			3'b010: base = 5'd14; // O-U
			3'b100: base = 5'd21; // V-Z
			default: begin
				base = 5'd0;
				group_ok = 1'b0;
			end
		endcase
		result = base + {2'b00, hot_pos};
		// Last group has only five letters
		if (!group_ok || hot_cnt != 3'd1 || result > 5'd25) begin
			result = `LETTER_NONE;
		end
		return result;
	endfunction

	function automatic level_t decode_level(input logic [`SW_W-1:0] sw);
		level_t result;
		case (sw)
			10'b1000000000: result = LVL_EASY;
			10'b0100000000: result = LVL_MEDIUM;
			10'b0010000000: result = LVL_HARD;
			default: result = LVL_NONE;
		endcase
		return result;
	endfunction

endpackage

//--- hw/entry/guess_collect.sv
`timescale 1ns/1ns
`include "wordle_consts.svh"

module guess_collect import wordle_pkg::*; (
	input logic clk,
	input logic reset,
	input logic accepting,
	input logic entry_valid,
	input entry_t entry,
	output logic guess_valid,
	output word_t guess,
	output word_t partial,
	output logic [2:0] count
);

	word_t word_next;
	logic take;

	assign take = accepting && entry_valid;

	// Partial guess with the incoming letter dropped in at count
	always_comb begin
		word_next = partial;
		word_next[count[1:0]] = entry.letter;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			guess_valid <= 1'b0;
		end else begin
			guess_valid <= 1'b0;
			if (!accepting) begin
				count <= '0; // Drop whatever was typed
			end else if (entry_valid) begin
				if (count == 3'(`WORD_LEN - 1)) begin
					count <= '0;
					guess_valid <= 1'b1;
				end else begin
					count <= count + 3'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			partial <= word_next;
			guess <= word_next;
		end
	end

	assert property (@(posedge clk) disable iff (reset) count < 3'(`WORD_LEN))
		else $error("guess_collect: count ran past the word length");

endmodule

//--- hw/entry/switch_decode.sv
`timescale 1ns/1ns
`include "wordle_consts.svh"

module switch_decode import wordle_pkg::*; (
	input logic clk,
	input logic reset,
	input logic enter,
	input logic [`SW_W-1:0] switches,
	output logic entry_valid,
	output entry_t entry
);

	entry_t entry_d;

	// Both readings of the same switch pattern
	always_comb begin
		entry_d.letter = decode_letter(switches);
		entry_d.level = decode_level(switches);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			entry_valid <= 1'b0;
		end else begin
			entry_valid <= enter; // Enter is already a one-cycle strobe
		end
	end

	always_ff @(posedge clk) begin
		if (enter) begin
			entry <= entry_d;
		end
	end

endmodule

//--- hw/game/game_ctrl.sv
`timescale 1ns/1ns
`include "wordle_consts.svh"

module game_ctrl import wordle_pkg::*; (
	input logic clk,
	input logic reset,
	input logic entry_valid,
	input entry_t entry,
	input logic score_valid,
	input score_t score,
	output logic accepting,
	output phase_t phase,
	output level_t level,
	output word_t secret,
	output logic [2:0] attempts,
	output mask_t last_mask
);

	logic [`SEL_W-1:0] sel_cnt;
	logic [`SEL_W-1:0] index;
	logic start;

	assign start = (phase == PH_IDLE) && entry_valid && (entry.level != LVL_NONE);
	assign accepting = (phase == PH_GUESSING);

	// Free-running pick of the secret word
	always_ff @(posedge clk) begin
		if (reset) begin
			sel_cnt <= '0;
		end else if (sel_cnt == `SEL_W'(`LEX_DEPTH - 1)) begin
			sel_cnt <= '0;
		end else begin
			sel_cnt <= sel_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			index <= sel_cnt;
		end
	end

	word_rom word_rom_inst (
		.level(level),
		.index(index),
		.word(secret)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= PH_IDLE;
			level <= LVL_NONE;
			attempts <= '0;
			last_mask <= '0;
		end else begin
			case (phase)
				PH_IDLE: begin
					if (start) begin
						phase <= PH_GUESSING;
						level <= entry.level;
						attempts <= '0;
						last_mask <= '0;
					end
				end
				PH_GUESSING: begin
					if (score_valid) begin
						last_mask <= score.mask;
						if (score.hit) begin
							phase <= PH_WON;
						end else begin
							attempts <= attempts + 3'd1;
							if (attempts == 3'(`MAX_GUESSES - 1)) begin
								phase <= PH_LOST; // Out of tries
							end
						end
					end
				end
				PH_WON, PH_REVEAL: begin
					if (entry_valid) phase <= PH_IDLE;
				end
				PH_LOST: begin
					if (entry_valid) phase <= PH_REVEAL; // Next press shows the word
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) attempts <= 3'(`MAX_GUESSES))
		else $error("game_ctrl: attempts above the guess limit");

endmodule

//--- hw/game/guess_score.sv
`timescale 1ns/1ns
`include "wordle_consts.svh"

module guess_score import wordle_pkg::*; (
	input logic clk,
	input logic reset,
	input logic guess_valid,
	input word_t guess,
	input word_t secret,
	output logic score_valid,
	output score_t score
);

	score_t score_d;

	always_comb begin
		for (int i = 0; i < `WORD_LEN; i++) begin
			// Invalid letter never matches
			score_d.mask[i] = (guess[i] == secret[i]) && (guess[i] != `LETTER_NONE);
		end
		score_d.hit = &score_d.mask;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			score_valid <= 1'b0;
		end else begin
			score_valid <= guess_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (guess_valid) begin
			score <= score_d;
		end
	end

	// A guess only arrives once a secret word has been chosen
	assert property (@(posedge clk) disable iff (reset)
		guess_valid |-> secret[0] != `LETTER_NONE)
		else $error("guess_score: guess scored against no secret word");

endmodule

//--- hw/game/word_rom.sv
`timescale 1ns/1ns
`include "wordle_consts.svh"

module word_rom import wordle_pkg::*; (
	input level_t level,
	input logic [`SEL_W-1:0] index,
	output word_t word
);

	// Letters as alphabet indices, A is 0
	always_comb begin
		word = {`WORD_LEN{`LETTER_NONE}};
		case (level)
			LVL_EASY: case (index)
				3'd0: word = {5'd2, 5'd0, 5'd6, 5'd4}; // cage
				3'd1: word = {5'd1, 5'd4, 5'd0, 5'd3}; // bead
				3'd2: word = {5'd4, 5'd3, 5'd6, 5'd4}; // edge
				3'd3: word = {5'd5, 5'd0, 5'd2, 5'd4}; // face
				3'd4: word = {5'd3, 5'd4, 5'd0, 5'd3}; // dead
				3'd5: word = {5'd5, 5'd4, 5'd4, 5'd3}; // feed
				3'd6: word = {5'd0, 5'd2, 5'd4, 5'd3}; // aced
				default: word = {5'd3, 5'd4, 5'd0, 5'd5}; // deaf
			endcase
			LVL_MEDIUM: case (index)
				3'd0: word = {5'd2, 5'd0, 5'd13, 5'd4}; // cane
				3'd1: word = {5'd11, 5'd0, 5'd13, 5'd3}; // land
				3'd2: word = {5'd1, 5'd4, 5'd0, 5'd13}; // bean
				3'd3: word = {5'd13, 5'd0, 5'd12, 5'd4}; // name
				3'd4: word = {5'd12, 5'd0, 5'd3, 5'd4}; // made
				3'd5: word = {5'd12, 5'd0, 5'd8, 5'd3}; // maid
				3'd6: word = {5'd11, 5'd0, 5'd13, 5'd4}; // lane
				default: word = {5'd7, 5'd0, 5'd13, 5'd3}; // hand
			endcase
			LVL_HARD: case (index)
				3'd0: word = {5'd2, 5'd14, 5'd3, 5'd4}; // code
				3'd1: word = {5'd11, 5'd14, 5'd21, 5'd4}; // love
				3'd2: word = {5'd5, 5'd11, 5'd8, 5'd15}; // flip
				3'd3: word = {5'd5, 5'd11, 5'd14, 5'd15}; // flop
				3'd4: word = {5'd5, 5'd15, 5'd6, 5'd0}; // fpga
				3'd5: word = {5'd1, 5'd11, 5'd20, 5'd4}; // blue
				3'd6: word = {5'd18, 5'd19, 5'd0, 5'd17}; // star
				default: word = {5'd5, 5'd8, 5'd17, 5'd4}; // fire
			endcase
			default: ; // No level picked yet
		endcase
	end

endmodule

//--- hw/seg_display.sv
`timescale 1ns/1ns
`include "wordle_consts.svh"

module seg_display import wordle_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [`SW_W-1:0] switches,
	input phase_t phase,
	input level_t level,
	input word_t secret,
	input word_t partial,
	input logic [2:0] count,
	input logic [2:0] attempts,
	input mask_t last_mask,
	output seg_word_t digits,
	output mask_t match_leds,
	output logic [3:0] attempt_leds,
	output status_t status
);

	localparam letter_t L_BLANK = 5'd30; // Display-only code for a dark digit
	localparam seg_word_t SELE_SEGS = {7'b0100100, 7'b0110000, 7'b1110001, 7'b0110000};

	word_t screen;
	letter_t live;
	seg_word_t digits_d;
	logic [2:0] capped;
	logic [4:0] thermo;

	// Active-low segment codes
	function automatic seg_t seg_of(input letter_t l);
		seg_t s;
		case (l)
			5'd0: s = 7'b0001000; 5'd1: s = 7'b1100000; 5'd2: s = 7'b0110001;
			5'd3: s = 7'b1000010; 5'd4: s = 7'b0110000; 5'd5: s = 7'b0111000;
			5'd6: s = 7'b0000100; 5'd7: s = 7'b1101000; 5'd8: s = 7'b1001111;
			5'd9: s = 7'b1000111; 5'd10: s = 7'b1111000; 5'd11: s = 7'b1110001;
			5'd12: s = 7'b1011010; 5'd13: s = 7'b1101010; 5'd14: s = 7'b0000001;
			5'd15: s = 7'b0011000; 5'd16: s = 7'b0001100; 5'd17: s = 7'b1111010;
			5'd18: s = 7'b0100100; 5'd19: s = 7'b1001110; 5'd20: s = 7'b1000001;
			5'd21: s = 7'b1101011; 5'd22: s = 7'b1001001; 5'd23: s = 7'b1001000;
			5'd24: s = 7'b1000100; 5'd25: s = 7'b0010010;
			L_BLANK: s = 7'b1111111;
			default: s = 7'b0000000; // Bad pattern lights everything
		endcase
		return s;
	endfunction

	assign live = decode_letter(switches);

	always_comb begin
		screen = {`WORD_LEN{L_BLANK}};
		case (phase)
			PH_IDLE: case (decode_level(switches))
				LVL_EASY: screen = {5'd4, 5'd0, 5'd18, 5'd24}; // EASY
				LVL_MEDIUM: screen = {5'd12, 5'd4, 5'd3, L_BLANK}; // MED
				LVL_HARD: screen = {5'd7, 5'd0, 5'd17, 5'd3}; // HARD
				default: screen = {5'd18, 5'd4, 5'd11, 5'd4}; // SELE
			endcase
			PH_GUESSING: begin
				for (int i = 0; i < `WORD_LEN; i++) begin
					if (i < int'(count)) screen[i] = partial[i];
					else if (i == int'(count)) screen[i] = live; // Echo of the switches
				end
			end
			PH_WON: screen = {5'd22, 5'd8, 5'd13, 5'd18}; // WINS
			PH_LOST: screen = {5'd11, 5'd14, 5'd18, 5'd4}; // LOSE
			PH_REVEAL: screen = secret;
			default: ;
		endcase
		for (int i = 0; i < `WORD_LEN; i++) begin
			digits_d[i] = seg_of(screen[i]);
		end
	end

	// Thermometer stops at four lit
	assign capped = (attempts > 3'd4) ? 3'd4 : attempts;
	assign thermo = (5'd1 << capped) - 5'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			digits <= SELE_SEGS;
			match_leds <= '0;
			attempt_leds <= '0;
			status <= '0;
		end else begin
			digits <= digits_d;
			match_leds <= (phase == PH_GUESSING) ? last_mask : '0;
			attempt_leds <= thermo[3:0];
			status.win <= (phase == PH_WON);
			status.lose <= (phase == PH_LOST) || (phase == PH_REVEAL);
		end
	end

	// A game in progress always has a level behind it
	assert property (@(posedge clk) disable iff (reset) phase == PH_GUESSING |-> level != LVL_NONE)
		else $error("seg_display: guessing with no level");

endmodule

//--- hw/wordle_top.sv
`timescale 1ns/1ns
`include "wordle_consts.svh"

module wordle_top import wordle_pkg::*; (
	input logic clk,
	input logic reset,
	input logic enter,
	input logic [`SW_W-1:0] switches,
	output seg_word_t digits,
	output mask_t match_leds,
	output logic [3:0] attempt_leds,
	output status_t status
);

	logic entry_valid;
	entry_t entry;
	logic accepting;
	logic guess_valid;
	word_t guess;
	word_t partial;
	logic [2:0] count;
	logic score_valid;
	score_t score;
	phase_t phase;
	level_t level;
	word_t secret;
	logic [2:0] attempts;
	mask_t last_mask;

	switch_decode switch_decode_inst (
		.clk(clk),
		.reset(reset),
		.enter(enter),
		.switches(switches),
		.entry_valid(entry_valid),
		.entry(entry)
	);

	guess_collect guess_collect_inst (
		.clk(clk),
		.reset(reset),
		.accepting(accepting),
		.entry_valid(entry_valid),
		.entry(entry),
		.guess_valid(guess_valid),
		.guess(guess),
		.partial(partial),
		.count(count)
	);

	guess_score guess_score_inst (
		.clk(clk),
		.reset(reset),
		.guess_valid(guess_valid),
		.guess(guess),
		.secret(secret),
		.score_valid(score_valid),
		.score(score)
	);

	game_ctrl game_ctrl_inst (
		.clk(clk),
		.reset(reset),
		.entry_valid(entry_valid),
		.entry(entry),
		.score_valid(score_valid),
		.score(score),
		.accepting(accepting),
		.phase(phase),
		.level(level),
		.secret(secret),
		.attempts(attempts),
		.last_mask(last_mask)
	);

	seg_display seg_display_inst (
		.clk(clk),
		.reset(reset),
		.switches(switches),
		.phase(phase),
		.level(level),
		.secret(secret),
		.partial(partial),
		.count(count),
		.attempts(attempts),
		.last_mask(last_mask),
		.digits(digits),
		.match_leds(match_leds),
		.attempt_leds(attempt_leds),
		.status(status)
	);

endmodule

//--- sim/tb_wordle.sv
`timescale 1ns/1ns
`include "wordle_consts.svh"

module tb_wordle import wordle_pkg::*; ();

	localparam int P_IDLE = 0;
	localparam int P_GUESSING = 1;
	localparam int P_WON = 2;
	localparam int P_LOST = 3;
	localparam int P_REVEAL = 4;
	localparam letter_t BLANK = 5'd30; // Dark digit in the model screen

	localparam logic [31:0] LEXICON [0:23] = '{
		"cage", "bead", "edge", "face", "dead", "feed", "aced", "deaf",
		"cane", "land", "bean", "name", "made", "maid", "lane", "hand",
		"code", "love", "flip", "flop", "fpga", "blue", "star", "fire"
	};

	// Active-low codes from A to Z
	localparam seg_t SEG_TABLE [0:25] = '{
		7'b0001000, 7'b1100000, 7'b0110001, 7'b1000010, 7'b0110000, 7'b0111000,
		7'b0000100, 7'b1101000, 7'b1001111, 7'b1000111, 7'b1111000, 7'b1110001,
		7'b1011010, 7'b1101010, 7'b0000001, 7'b0011000, 7'b0001100, 7'b1111010,
		7'b0100100, 7'b1001110, 7'b1000001, 7'b1101011, 7'b1001001, 7'b1001000,
		7'b1000100, 7'b0010010
	};

	logic clk;
	logic reset;
	logic enter;
	logic [`SW_W-1:0] switches;
	seg_word_t digits;
	mask_t match_leds;
	logic [3:0] attempt_leds;
	status_t status;

	logic [31:0] lfsr;
	int edge_cnt;
	int errors;
	int checks;
	int tests;
	int test_start;
	int m_phase;
	int m_count;
	int m_attempts;
	mask_t m_mask;
	word_t m_secret;
	word_t m_partial;
	word_t g;

	wordle_top wordle_top_inst (
		.clk(clk),
		.reset(reset),
		.enter(enter),
		.switches(switches),
		.digits(digits),
		.match_leds(match_leds),
		.attempt_leds(attempt_leds),
		.status(status)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Mirrors the free-running word counter
	always @(posedge clk) begin
		if (reset) edge_cnt <= 0;
		else edge_cnt <= edge_cnt + 1;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	// Lower case text to letter indices with space as blank
	function automatic word_t text_word(input logic [31:0] t);
		word_t w;
		logic [7:0] ch;
		for (int i = 0; i < 4; i++) begin
			ch = t[31 - 8 * i -: 8];
			w[i] = (ch == 8'h20) ? BLANK : letter_t'(ch - 8'h61);
		end
		return w;
	endfunction

	function automatic seg_word_t word_segs(input word_t w);
		seg_word_t d;
		for (int i = 0; i < 4; i++) begin
			if (w[i] < 5'd26) d[i] = SEG_TABLE[w[i]];
			else if (w[i] == BLANK) d[i] = 7'b1111111;
			else d[i] = 7'b0000000; // Unknown pattern lights all
		end
		return d;
	endfunction

	function automatic letter_t model_letter(input logic [9:0] sw);
		int base;
		int pos;
		base = -1;
		pos = 0;
		if (sw[2:0] == 3'b000) base = 0;
		else if (sw[2:0] == 3'b001) base = 7;
		else if (sw[2:0] == 3'b010) base = 14;
		else if (sw[2:0] == 3'b100) base = 21;
		for (int b = 3; b <= 9; b++) begin
			if (sw[b]) pos = 9 - b;
		end
		if (base < 0 || $countones(sw[9:3]) != 1 || base + pos > 25) return 5'd31;
		return letter_t'(base + pos);
	endfunction

	function automatic int model_level(input logic [9:0] sw);
		if (sw == 10'b1000000000) return 1;
		if (sw == 10'b0100000000) return 2;
		if (sw == 10'b0010000000) return 3;
		return 0;
	endfunction

	function automatic logic [9:0] letter_switches(input letter_t l);
		logic [9:0] sw;
		sw = '0;
		sw[9 - int'(l) % 7] = 1'b1;
		case (int'(l) / 7)
			1: sw[0] = 1'b1;
			2: sw[1] = 1'b1;
			3: sw[2] = 1'b1;
			default: ;
		endcase
		return sw;
	endfunction

	function automatic logic [9:0] level_switches(input int lvl);
		logic [9:0] sw;
		sw = '0;
		sw[10 - lvl] = 1'b1; // Easy is bit 9
		return sw;
	endfunction

	function automatic seg_word_t expected_digits(input logic [9:0] sw);
		word_t t;
		case (m_phase)
			P_IDLE: case (model_level(sw))
				1: t = text_word("easy");
				2: t = text_word("med ");
				3: t = text_word("hard");
				default: t = text_word("sele");
			endcase
			P_GUESSING: begin
				for (int i = 0; i < 4; i++) begin
					if (i < m_count) t[i] = m_partial[i];
					else if (i == m_count) t[i] = model_letter(sw);
					else t[i] = BLANK;
				end
			end
			P_WON: t = text_word("wins");
			P_LOST: t = text_word("lose");
			default: t = m_secret;
		endcase
		return word_segs(t);
	endfunction

	function automatic word_t random_guess(input bit force_wrong);
		word_t w;
		for (int i = 0; i < 4; i++) begin
			if (rand_bits(1) == 1) w[i] = m_secret[i];
			else w[i] = letter_t'(rand_bits(5) % 26);
		end
		if (force_wrong && w == m_secret) w[3] = letter_t'((int'(m_secret[3]) + 1) % 26);
		return w;
	endfunction

	task automatic model_press(input logic [9:0] sw, input int idx);
		mask_t hits;
		case (m_phase)
			P_IDLE: begin
				if (model_level(sw) != 0) begin
					m_phase = P_GUESSING;
					m_secret = text_word(LEXICON[(model_level(sw) - 1) * 8 + idx]);
					m_attempts = 0;
					m_mask = '0;
					m_count = 0;
				end
			end
			P_GUESSING: begin
				m_partial[m_count] = model_letter(sw);
				m_count++;
				if (m_count == 4) begin
					m_count = 0;
					for (int i = 0; i < 4; i++) begin
						hits[i] = (m_partial[i] == m_secret[i]) && (m_partial[i] != 5'd31);
					end
					m_mask = hits;
					if (&hits) begin
						m_phase = P_WON;
					end else begin
						m_attempts++;
						if (m_attempts == `MAX_GUESSES) m_phase = P_LOST;
					end
				end
			end
			P_LOST: m_phase = P_REVEAL;
			default: m_phase = P_IDLE; // Won or reveal
		endcase
	endtask

	task automatic check_digits(input string test, input seg_word_t expected);
		checks++;
		if (digits !== expected) begin
			errors++;
			$display("ERROR %s digits: expected %h, actual %h", test, expected, digits);
		end
	endtask

	task automatic check_mask(input string test, input mask_t expected);
		checks++;
		if (match_leds !== expected) begin
			errors++;
			$display("ERROR %s match_leds: expected %b, actual %b", test, expected,
				match_leds);
		end
	endtask

	task automatic check_attempts(input string test, input logic [3:0] expected);
		checks++;
		if (attempt_leds !== expected) begin
			errors++;
			$display("ERROR %s attempt_leds: expected %b, actual %b", test, expected,
				attempt_leds);
		end
	endtask

	task automatic check_status(input string test, input status_t expected);
		checks++;
		if (status !== expected) begin
			errors++;
			$display("ERROR %s status: expected %b, actual %b", test, expected, status);
		end
	endtask

	task automatic check_outputs(input string test);
		status_t s;
		logic [3:0] leds;
		s.win = (m_phase == P_WON);
		s.lose = (m_phase == P_LOST) || (m_phase == P_REVEAL);
		// One LED per miss, four at most
		for (int i = 0; i < 4; i++) begin
			leds[i] = (i < m_attempts);
		end
		check_digits(test, expected_digits(switches));
		check_mask(test, (m_phase == P_GUESSING) ? m_mask : 4'b0000);
		check_attempts(test, leds);
		check_status(test, s);
	endtask

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
		end
	endtask

	task automatic wait_for_idle(input int limit);
		int n;
		n = 0;
		while (digits !== word_segs(text_word("sele")) && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (digits !== word_segs(text_word("sele"))) begin
			errors++;
			$display("Timeout: idle screen not shown within %0d cycles after reset", limit);
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		enter = 1'b0;
		switches = '0;
		for (int i = 0; i < 2; i++) begin
			@(posedge clk);
		end
		@(negedge clk);
		reset = 1'b0;
		m_phase = P_IDLE;
		m_attempts = 0;
		m_mask = '0;
		m_count = 0;
		wait_for_idle(10);
	endtask

	// Enter strobe, check after five cycles, then the rest of the gap
	task automatic press(input string test, input logic [9:0] sw);
		int gap;
		gap = 6 + rand_bits(2);
		switches = sw;
		enter = 1'b1;
		@(negedge clk);
		enter = 1'b0;
		model_press(sw, edge_cnt % `LEX_DEPTH);
		wait_cycles(4);
		check_outputs(test);
		wait_cycles(gap - 5);
	endtask

	task automatic set_switches(input string test, input logic [9:0] sw);
		switches = sw;
		wait_cycles(2);
		check_outputs(test);
	endtask

	task automatic type_letters(input string test, input word_t w,
		input int first, input int last);
		for (int i = first; i <= last; i++) begin
			press(test, letter_switches(w[i]));
		end
	endtask

	task automatic start_game(input string test);
		press(test, level_switches(1 + rand_bits(2) % 3));
	endtask

	task automatic finish_test(input string test);
		tests++;
		$display("Test %s done with %0d errors", test, errors - test_start);
		test_start = errors;
	endtask

	initial begin
		reset = 1'b1;
		enter = 1'b0;
		switches = '0;
		lfsr = 32'h7256;
		errors = 0;
		checks = 0;
		tests = 0;
		test_start = 0;
		m_secret = '0;
		m_partial = '0;
		apply_reset();

		check_outputs("idle_screen");
		for (int l = 1; l <= 3; l++) begin
			set_switches("idle_screen", level_switches(l));
		end
		set_switches("idle_screen", 10'b1100000000); // Two levels at once
		finish_test("idle_screen");

		start_game("letter_echo");
		g = random_guess(1'b1);
		type_letters("letter_echo", g, 0, 1);
		for (int i = 0; i < 8; i++) begin
			if (i % 2 == 0) begin
				set_switches("letter_echo", letter_switches(letter_t'(rand_bits(5) % 26)));
			end else begin
				set_switches("letter_echo", 10'(rand_bits(10)));
			end
		end
		set_switches("letter_echo", 10'b0001000011); // Bad group code
		finish_test("letter_echo");

		type_letters("wrong_guess", g, 2, 3);
		for (int n = 0; n < 2; n++) begin
			g = random_guess(1'b1);
			type_letters("wrong_guess", g, 0, 3);
		end
		finish_test("wrong_guess");

		apply_reset();
		set_switches("reset_mid_game", 10'b0000000000);
		start_game("reset_mid_game");
		g = random_guess(1'b1);
		type_letters("reset_mid_game", g, 0, 3);
		finish_test("reset_mid_game");

		g = m_secret;
		type_letters("winning_guess", g, 0, 3);
		press("winning_guess", 10'b0000000000);
		finish_test("winning_guess");

		start_game("losing_game");
		for (int n = 0; n < `MAX_GUESSES; n++) begin
			g = random_guess(1'b1);
			type_letters("losing_game", g, 0, 3);
		end
		press("losing_game", 10'b0000000000); // Shows the secret
		press("losing_game", 10'b0000000000);
		finish_test("losing_game");

		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+common
common/wordle_pkg.sv
hw/entry/switch_decode.sv
hw/entry/guess_collect.sv
hw/game/word_rom.sv
hw/game/guess_score.sv
hw/game/game_ctrl.sv
hw/seg_display.sv
hw/wordle_top.sv
sim/tb_wordle.sv
